//--- mipsIsaPkg.sv
`default_nettype none

package mipsIsaPkg;

    // Register-format word
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFormat;

    // Immediate-format word
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iFormat;

    // Same 32 bits, two views
    typedef union packed {
        rFormat r;
        iFormat i;
    } mipsInstruction;

    // ------------------------------------------------------------
    // Opcodes
    // ------------------------------------------------------------
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opAddi    = 6'h08;
    localparam logic [5:0] opSlti    = 6'h0A;
    localparam logic [5:0] opAndi    = 6'h0C;
    localparam logic [5:0] opOri     = 6'h0D;
    localparam logic [5:0] opXori    = 6'h0E;
    localparam logic [5:0] opLui     = 6'h0F;

    // ------------------------------------------------------------
    // Function codes under opSpecial
    // ------------------------------------------------------------
    localparam logic [5:0] fnSll = 6'h00;
    localparam logic [5:0] fnSrl = 6'h02;
    localparam logic [5:0] fnAdd = 6'h20;
    localparam logic [5:0] fnSub = 6'h22;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnOr  = 6'h25;
    localparam logic [5:0] fnXor = 6'h26;
    localparam logic [5:0] fnSlt = 6'h2A;

endpackage

`default_nettype wire

//--- mipsPipePkg.sv
`default_nettype none

package mipsPipePkg;

    // Register value as it moves through the pipeline
    typedef logic [31:0] dataWord;

    // Register number
    typedef logic [4:0] regIndex;

    // Architectural register count
    localparam int regCount = 32;

endpackage

`default_nettype wire

//--- mipsIssueIf.sv
`default_nettype none

interface mipsIssueIf
    import mipsIsaPkg::*, mipsPipePkg::*;
();

    logic           rValid;
    logic           iValid;
    mipsInstruction instruction;
    dataWord        operandA;
    dataWord        operandB;
    regIndex        dest;

    // Issue stage drives everything
    modport source (
        output rValid, iValid, instruction, operandA, operandB, dest
    );

    // Both execution units listen
    modport exec (
        input rValid, iValid, instruction, operandA, operandB, dest
    );

endinterface

`default_nettype wire

//--- mipsRegisterFile.sv
`default_nettype none

module mipsRegisterFile
    import mipsPipePkg::*;
(
    input  logic    Clock,
    input  logic    Reset,
    input  regIndex readIndexA,
    input  regIndex readIndexB,
    input  regIndex viewIndex,
    output dataWord readDataA,
    output dataWord readDataB,
    output dataWord viewData,
    input  logic    writeEnable,
    input  regIndex writeIndex,
    input  dataWord writeData
);

    dataWord regs [regCount];

    // Register 0 is never loaded, so it stays at zero
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            for (int n = 0; n < regCount; n++) begin
                regs[n] <= '0;
            end
        end else if (writeEnable && writeIndex != '0) begin
            regs[writeIndex] <= writeData;
        end
    end

    assign readDataA = regs[readIndexA];
    assign readDataB = regs[readIndexB];
    assign viewData  = regs[viewIndex];

    // Writeback must already drop writes to register 0
    noZeroWrite: assert property (@(posedge Clock) disable iff (Reset)
        !(writeEnable && writeIndex == '0));

endmodule

`default_nettype wire

//--- mipsIssue.sv
`default_nettype none

module mipsIssue
    import mipsIsaPkg::*, mipsPipePkg::*;
(
    input  logic           Clock,
    input  logic           Reset,
    input  logic           insValid,
    input  mipsInstruction insWord,
    output regIndex        readIndexA,
    output regIndex        readIndexB,
    input  dataWord        readDataA,
    input  dataWord        readDataB,
    input  logic           bypassValid,
    input  regIndex        bypassIndex,
    input  dataWord        bypassData,
    output logic           illegal,
    mipsIssueIf.source     issue
);

    logic           isRegOp;
    logic           isImmOp;
    logic           rValidQ;
    logic           iValidQ;
    mipsInstruction heldWord;
    regIndex        destQ;
    logic           forwardA;
    logic           forwardB;

    // ------------------------------------------------------------
    // Classification of the strobed word
    // ------------------------------------------------------------
    always_comb begin
        isRegOp = 1'b0;
        if (insWord.r.opcode == opSpecial) begin
            case (insWord.r.funct)
                fnAdd, fnSub, fnAnd, fnOr, fnXor, fnSlt, fnSll, fnSrl: isRegOp = 1'b1;
                default: isRegOp = 1'b0;
            endcase
        end
    end

    always_comb begin
        case (insWord.i.opcode)
            opAddi, opSlti, opAndi, opOri, opXori, opLui: isImmOp = 1'b1;
            default: isImmOp = 1'b0;
        endcase
    end

    // Issue registers, loaded on the strobe edge
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            rValidQ  <= 1'b0;
            iValidQ  <= 1'b0;
            illegal  <= 1'b0;
            heldWord <= '0;
            destQ    <= '0;
        end else begin
            rValidQ <= insValid && isRegOp;
            iValidQ <= insValid && isImmOp;
            illegal <= insValid && !isRegOp && !isImmOp;
            if (insValid) begin
                heldWord <= insWord;
                // rd for R-format, rt for I-format
                destQ    <= isRegOp ? insWord.r.rd : insWord.i.rt;
            end
        end
    end

    // ------------------------------------------------------------
    // Operand read with bypass from the ALU result registers
    // ------------------------------------------------------------
    assign readIndexA = heldWord.r.rs;
    assign readIndexB = heldWord.r.rt;

    assign forwardA = bypassValid && bypassIndex == readIndexA && readIndexA != '0;
    assign forwardB = bypassValid && bypassIndex == readIndexB && readIndexB != '0;

    assign issue.operandA    = forwardA ? bypassData : readDataA;
    assign issue.operandB    = forwardB ? bypassData : readDataB;
    assign issue.rValid      = rValidQ;
    assign issue.iValid      = iValidQ;
    assign issue.instruction = heldWord;
    assign issue.dest        = destQ;

    oneUnitOnly: assert property (@(posedge Clock) disable iff (Reset)
        !(rValidQ && iValidQ));

endmodule

`default_nettype wire

//--- mipsRegisterAlu.sv
`default_nettype none

module mipsRegisterAlu
    import mipsIsaPkg::*, mipsPipePkg::*;
(
    input  logic     Clock,
    input  logic     Reset,
    mipsIssueIf.exec exec,
    output logic     resultValid,
    output regIndex  resultIndex,
    output dataWord  resultData
);

    dataWord aluValue;

    always_comb begin
        case (exec.instruction.r.funct)
            fnAdd:   aluValue = exec.operandA + exec.operandB;
            fnSub:   aluValue = exec.operandA - exec.operandB;
            fnAnd:   aluValue = exec.operandA & exec.operandB;
            fnOr:    aluValue = exec.operandA | exec.operandB;
            fnXor:   aluValue = exec.operandA ^ exec.operandB;
            // Signed compare, result is 1 or 0
            fnSlt:   aluValue = {31'b0, $signed(exec.operandA) < $signed(exec.operandB)};
            fnSll:   aluValue = exec.operandB << exec.instruction.r.shamt;
            fnSrl:   aluValue = exec.operandB >> exec.instruction.r.shamt;
            default: aluValue = '0;
        endcase
    end

    // Result register, one cycle after issue
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            resultValid <= 1'b0;
            resultIndex <= '0;
            resultData  <= '0;
        end else begin
            resultValid <= exec.rValid;
            if (exec.rValid) begin
                resultIndex <= exec.dest;
                resultData  <= aluValue;
            end
        end
    end

endmodule

`default_nettype wire

//--- mipsImmediateAlu.sv
`default_nettype none

module mipsImmediateAlu
    import mipsIsaPkg::*, mipsPipePkg::*;
(
    input  logic     Clock,
    input  logic     Reset,
    mipsIssueIf.exec exec,
    output logic     resultValid,
    output regIndex  resultIndex,
    output dataWord  resultData
);

    dataWord signImm;
    dataWord zeroImm;
    dataWord aluValue;

    assign signImm = {{16{exec.instruction.i.imm[15]}}, exec.instruction.i.imm};
    assign zeroImm = {16'h0000, exec.instruction.i.imm};

    always_comb begin
        case (exec.instruction.i.opcode)
            opAddi:  aluValue = exec.operandA + signImm;
            opSlti:  aluValue = {31'b0, $signed(exec.operandA) < $signed(signImm)};
            opAndi:  aluValue = exec.operandA & zeroImm;
            opOri:   aluValue = exec.operandA | zeroImm;
            opXori:  aluValue = exec.operandA ^ zeroImm;
            // Upper half loaded, lower half cleared
            opLui:   aluValue = {exec.instruction.i.imm, 16'h0000};
            default: aluValue = '0;
        endcase
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            resultValid <= 1'b0;
            resultIndex <= '0;
            resultData  <= '0;
        end else begin
            resultValid <= exec.iValid;
            if (exec.iValid) begin
                resultIndex <= exec.dest;
                resultData  <= aluValue;
            end
        end
    end

endmodule

`default_nettype wire

//--- mipsWriteback.sv
`default_nettype none

module mipsWriteback
    import mipsPipePkg::*;
(
    input  logic    Clock,
    input  logic    Reset,
    input  logic    rValid,
    input  logic    iValid,
    input  regIndex rIndex,
    input  regIndex iIndex,
    input  dataWord rData,
    input  dataWord iData,
    output logic    writeEnable,
    output regIndex writeIndex,
    output dataWord writeData,
    output logic    retireValid,
    output regIndex retireIndex,
    output dataWord retireValue
);

    logic anyValid;

    // Pick the unit that holds a result
    assign anyValid   = rValid || iValid;
    assign writeIndex = rValid ? rIndex : iIndex;
    assign writeData  = (writeIndex == '0) ? '0 : (rValid ? rData : iData);

    // Register 0 retires but is never written
    assign writeEnable = anyValid && writeIndex != '0;

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            retireValid <= 1'b0;
            retireIndex <= '0;
            retireValue <= '0;
        end else begin
            retireValid <= anyValid;
            retireIndex <= writeIndex;
            retireValue <= writeData;
        end
    end

    unitsExclusive: assert property (@(posedge Clock) disable iff (Reset)
        !(rValid && iValid));

endmodule

`default_nettype wire

//--- mipsRegisterViewer.sv
`default_nettype none

module mipsRegisterViewer
    import mipsPipePkg::*;
#(
    parameter int LedWidth = 16
) (
    input  logic                Clock,
    input  logic                Reset,
    input  logic                btn,
    output regIndex             viewIndex,
    input  dataWord             viewData,
    output logic [LedWidth-1:0] leds
);

    logic    btnLast;
    regIndex index;
    dataWord selected;

    // Index wraps around 32 through its own width
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            btnLast  <= 1'b0;
            index    <= '0;
            selected <= '0;
            leds     <= '0;
        end else begin
            btnLast <= btn;
            if (btn && !btnLast) begin
                index <= index + 1'b1;
            end
            selected <= viewData;
            leds     <= selected[LedWidth-1:0];
        end
    end

    assign viewIndex = index;

endmodule

`default_nettype wire

//--- mipsCore.sv
`default_nettype none

module mipsCore
    import mipsPipePkg::*;
(
    input  logic        Clock,
    input  logic        Reset,
    input  logic        insValid,
    input  logic [31:0] insWord,
    input  logic        btn,
    output logic [15:0] leds,
    output logic        illegal,
    output logic        retireValid,
    output logic [4:0]  retireIndex,
    output logic [31:0] retireValue
);

    // ------------------------------------------------------------
    // Internal wiring
    // ------------------------------------------------------------
    regIndex readIndexA;
    regIndex readIndexB;
    dataWord readDataA;
    dataWord readDataB;
    regIndex viewIndex;
    dataWord viewData;

    logic    writeEnable;
    regIndex writeIndex;
    dataWord writeData;

    logic    rValid;
    logic    iValid;
    regIndex rIndex;
    regIndex iIndex;
    dataWord rData;
    dataWord iData;

    mipsIssueIf issueBus ();

    mipsRegisterFile u_registerFile (
        .Clock       (Clock),
        .Reset       (Reset),
        .readIndexA  (readIndexA),
        .readIndexB  (readIndexB),
        .viewIndex   (viewIndex),
        .readDataA   (readDataA),
        .readDataB   (readDataB),
        .viewData    (viewData),
        .writeEnable (writeEnable),
        .writeIndex  (writeIndex),
        .writeData   (writeData)
    );

    // Bypass is the writeback triple itself
    mipsIssue u_issue (
        .Clock       (Clock),
        .Reset       (Reset),
        .insValid    (insValid),
        .insWord     (insWord),
        .readIndexA  (readIndexA),
        .readIndexB  (readIndexB),
        .readDataA   (readDataA),
        .readDataB   (readDataB),
        .bypassValid (writeEnable),
        .bypassIndex (writeIndex),
        .bypassData  (writeData),
        .illegal     (illegal),
        .issue       (issueBus.source)
    );

    mipsRegisterAlu u_registerAlu (
        .Clock       (Clock),
        .Reset       (Reset),
        .exec        (issueBus.exec),
        .resultValid (rValid),
        .resultIndex (rIndex),
        .resultData  (rData)
    );

    mipsImmediateAlu u_immediateAlu (
        .Clock       (Clock),
        .Reset       (Reset),
        .exec        (issueBus.exec),
        .resultValid (iValid),
        .resultIndex (iIndex),
        .resultData  (iData)
    );

    mipsWriteback u_writeback (
        .Clock       (Clock),
        .Reset       (Reset),
        .rValid      (rValid),
        .iValid      (iValid),
        .rIndex      (rIndex),
        .iIndex      (iIndex),
        .rData       (rData),
        .iData       (iData),
        .writeEnable (writeEnable),
        .writeIndex  (writeIndex),
        .writeData   (writeData),
        .retireValid (retireValid),
        .retireIndex (retireIndex),
        .retireValue (retireValue)
    );

    mipsRegisterViewer #(
        .LedWidth (16)
    ) u_registerViewer (
        .Clock     (Clock),
        .Reset     (Reset),
        .btn       (btn),
        .viewIndex (viewIndex),
        .viewData  (viewData),
        .leds      (leds)
    );

endmodule

`default_nettype wire

//--- tbClockGen.sv
`default_nettype none

module tbClockGen #(
    parameter int HalfPeriod = 20
) (
    output logic Clock
);
    timeunit 1ns;
    timeprecision 1ps;

    // Free-running clock, 40 ns period by default
    initial begin
        Clock = 1'b0;
        forever #HalfPeriod Clock = ~Clock;
    end

endmodule

`default_nettype wire

//--- mipsCoreTb.sv
`default_nettype none

module mipsCoreTb
    import mipsIsaPkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic        Clock;
    logic        Reset;
    logic        insValid;
    logic [31:0] insWord;
    logic        btn;
    logic [15:0] leds;
    logic        illegal;
    logic        retireValid;
    logic [4:0]  retireIndex;
    logic [31:0] retireValue;

    // Operation tables for random selection
    localparam logic [7:0][5:0] regFuncts = {fnAdd, fnSub, fnAnd, fnOr,
                                             fnXor, fnSlt, fnSll, fnSrl};
    localparam logic [5:0][5:0] immOps = {opAddi, opSlti, opAndi, opOri, opXori, opLui};
    localparam logic [5:0][5:0] badFuncts = {6'h03, 6'h08, 6'h21, 6'h23, 6'h27, 6'h2B};
    localparam logic [5:0][5:0] badOps = {6'h02, 6'h04, 6'h09, 6'h0B, 6'h23, 6'h2B};

    logic [31:0] rngState = 32'd96290;
    logic [31:0] modelRegs [32] = '{default: '0};
    int          retireAt [$];
    logic [4:0]  retireIdx [$];
    logic [31:0] retireVal [$];
    int          illegalAt [$];
    int          cycleCount = 0;
    int          mismatchCount = 0;
    int          otherErrors = 0;

    logic        expRetireValid = 1'b0;
    logic [4:0]  expRetireIndex = '0;
    logic [31:0] expRetireValue = '0;
    logic        expIllegal = 1'b0;
    logic [15:0] expLeds = '0;
    logic        ledCheckOn = 1'b0;
    logic        buttonUsed = 1'b0;
    logic [4:0]  viewPos = '0;

    tbClockGen u_clockGen (.Clock(Clock));

    mipsCore u_mipsCore (
        .Clock       (Clock),
        .Reset       (Reset),
        .insValid    (insValid),
        .insWord     (insWord),
        .btn         (btn),
        .leds        (leds),
        .illegal     (illegal),
        .retireValid (retireValid),
        .retireIndex (retireIndex),
        .retireValue (retireValue)
    );

    // ------------------------------------------------------------
    // Expected outputs per cycle from the model queues
    // ------------------------------------------------------------
    always @(posedge Clock) begin
        cycleCount = cycleCount + 1;
        expRetireValid = 1'b0;
        expIllegal = 1'b0;
        if (retireAt.size() != 0 && retireAt[0] == cycleCount) begin
            expRetireValid = 1'b1;
            expRetireIndex = retireIdx.pop_front();
            expRetireValue = retireVal.pop_front();
            void'(retireAt.pop_front());
        end
        if (illegalAt.size() != 0 && illegalAt[0] == cycleCount) begin
            expIllegal = 1'b1;
            void'(illegalAt.pop_front());
        end
    end

    task automatic reportMismatch(input string name, input logic [31:0] actual,
                                  input logic [31:0] expected);
        $display("MISMATCH at %0t ns: %s is 0x%0h, expected 0x%0h",
                 $time, name, actual, expected);
        mismatchCount++;
    endtask

    // Outputs checked on the falling edge where they have settled
    retireTiming: assert property (@(negedge Clock) retireValid == expRetireValid)
        else reportMismatch("retireValid", {31'b0, retireValid}, {31'b0, expRetireValid});
    retireIndexOk: assert property (@(negedge Clock) disable iff (Reset)
        retireValid && expRetireValid |-> retireIndex == expRetireIndex)
        else reportMismatch("retireIndex", {27'b0, retireIndex}, {27'b0, expRetireIndex});
    retireValueOk: assert property (@(negedge Clock) disable iff (Reset)
        retireValid && expRetireValid |-> retireValue == expRetireValue)
        else reportMismatch("retireValue", retireValue, expRetireValue);
    illegalTiming: assert property (@(negedge Clock) illegal == expIllegal)
        else reportMismatch("illegal", {31'b0, illegal}, {31'b0, expIllegal});
    ledsIdle: assert property (@(negedge Clock) !buttonUsed |-> leds == '0)
        else reportMismatch("leds", {16'b0, leds}, 32'b0);
    ledsShown: assert property (@(negedge Clock) ledCheckOn |-> leds == expLeds)
        else reportMismatch("leds", {16'b0, leds}, {16'b0, expLeds});

    // ------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] nextRandom();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return {8'h00, rngState[31:8]};
    endfunction

    function automatic logic [4:0] randomReg();
        logic [31:0] bits;
        bits = nextRandom();
        return bits[4:0];
    endfunction

    function automatic logic [31:0] makeR(input logic [5:0] funct, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [4:0] shamt);
        return {opSpecial, rs, rt, rd, shamt, funct};
    endfunction

    function automatic logic [31:0] makeI(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // I-format words use dest as rt and ignore srcB
    function automatic logic [31:0] randomLegal(input logic [4:0] srcA, input logic [4:0] srcB,
                                                input logic [4:0] dest);
        logic [31:0] choice;
        logic [31:0] bits;
        logic [2:0]  sel;
        choice = nextRandom() % 14;
        bits = nextRandom();
        if (choice < 8) begin
            return makeR(regFuncts[choice[2:0]], srcA, srcB, dest, bits[4:0]);
        end
        sel = 3'(choice - 8);
        return makeI(immOps[sel], srcA, dest, bits[15:0]);
    endfunction

    function automatic logic [31:0] randomIllegal();
        logic [31:0] choice;
        logic [31:0] bits;
        logic [2:0]  sel;
        choice = nextRandom() % 12;
        bits = nextRandom();
        sel = (choice < 6) ? 3'(choice) : 3'(choice - 6);
        if (choice < 6) begin
            return makeR(badFuncts[sel], bits[4:0], bits[9:5], bits[14:10], bits[19:15]);
        end
        return makeI(badOps[sel], bits[4:0], bits[9:5], bits[23:8]);
    endfunction

    // Reference model applied in strobe order
    task automatic modelStep(input logic [31:0] word, input int strobeCycle);
        logic [5:0]  op;
        logic [5:0]  funct;
        logic [4:0]  dest;
        logic [4:0]  shamt;
        logic [15:0] imm;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] signImm;
        logic [31:0] value;
        logic        legal;
        op = word[31:26];
        funct = word[5:0];
        shamt = word[10:6];
        imm = word[15:0];
        a = modelRegs[word[25:21]];
        b = modelRegs[word[20:16]];
        signImm = {{16{imm[15]}}, imm};
        legal = 1'b1;
        value = '0;
        dest = word[20:16];
        if (op == opSpecial) begin
            dest = word[15:11];
            case (funct)
                fnAdd: value = a + b;
                fnSub: value = a - b;
                fnAnd: value = a & b;
                fnOr: value = a | b;
                fnXor: value = a ^ b;
                // Flipping the sign bit turns signed order into unsigned order
                fnSlt: value = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
                fnSll: value = b << shamt;
                fnSrl: value = b >> shamt;
                default: legal = 1'b0;
            endcase
        end else begin
            case (op)
                opAddi: value = a + signImm;
                opSlti: value = ((a ^ 32'h8000_0000) < (signImm ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
                opAndi: value = a & {16'h0000, imm};
                opOri: value = a | {16'h0000, imm};
                opXori: value = a ^ {16'h0000, imm};
                opLui: value = {imm, 16'h0000};
                default: legal = 1'b0;
            endcase
        end
        if (!legal) begin
            illegalAt.push_back(strobeCycle + 1);
        end else begin
            if (dest == 5'd0) begin
                value = '0;
            end else begin
                modelRegs[dest] = value;
            end
            retireAt.push_back(strobeCycle + 3);
            retireIdx.push_back(dest);
            retireVal.push_back(value);
        end
    endtask

    task automatic sendWord(input logic [31:0] word);
        @(posedge Clock);
        #1;
        insValid = 1'b1;
        insWord = word;
        modelStep(word, cycleCount);
    endtask

    task automatic releaseBus();
        @(posedge Clock);
        #1;
        insValid = 1'b0;
        insWord = '0;
    endtask

    task automatic waitDrained();
        int waited;
        waited = 0;
        while ((retireAt.size() != 0 || illegalAt.size() != 0) && waited < 20) begin
            @(negedge Clock);
            waited++;
        end
        if (retireAt.size() != 0 || illegalAt.size() != 0) begin
            $display("Timeout at %0t ns: expected retires or illegal pulses never came", $time);
            otherErrors++;
        end
    endtask

    // Step the viewer and check the selected register on the LEDs
    task automatic showRegister(input int presses);
        buttonUsed = 1'b1;
        for (int p = 0; p < presses; p++) begin
            @(posedge Clock);
            #1 btn = 1'b1;
            @(posedge Clock);
            #1 btn = 1'b0;
        end
        viewPos = viewPos + 5'(presses);
        expLeds = modelRegs[viewPos][15:0];
        // LEDs follow the index two edges after the last press
        repeat (2) @(posedge Clock);
        #1 ledCheckOn = 1'b1;
        repeat (4) @(posedge Clock);
        #1 ledCheckOn = 1'b0;
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        logic [4:0]  lastDest;
        logic [4:0]  prevDest;
        logic [4:0]  rd;
        logic [31:0] coin;
        Reset = 1'b1;
        insValid = 1'b0;
        insWord = '0;
        btn = 1'b0;
        repeat (10) @(posedge Clock);
        #1 Reset = 1'b0;
        repeat (3) @(posedge Clock);

        // Fill every register through lui and a dependent ori
        for (int r = 1; r < 32; r++) begin
            coin = nextRandom();
            sendWord(makeI(opLui, 5'd0, 5'(r), coin[15:0]));
            sendWord(makeI(opOri, 5'(r), 5'(r), coin[23:8]));
        end

        // Random back-to-back mix
        for (int n = 0; n < 80; n++) begin
            sendWord(randomLegal(randomReg(), randomReg(), randomReg()));
        end

        // Chains on the previous result or the one before
        lastDest = 5'd2;
        prevDest = 5'd1;
        for (int n = 0; n < 40; n++) begin
            coin = nextRandom();
            rd = randomReg();
            if (rd == 5'd0) begin
                rd = 5'd3;
            end
            if (coin[0]) begin
                sendWord(randomLegal(lastDest, prevDest, rd));
            end else begin
                sendWord(randomLegal(prevDest, lastDest, rd));
            end
            prevDest = lastDest;
            lastDest = rd;
        end

        // Register 0 as destination and as source
        sendWord(makeI(opAddi, 5'd5, 5'd0, 16'h1234));
        sendWord(makeR(fnAdd, 5'd0, 5'd0, 5'd7, 5'd0));
        sendWord(makeR(fnOr, 5'd0, 5'd3, 5'd0, 5'd0));
        sendWord(makeR(fnXor, 5'd0, 5'd4, 5'd8, 5'd0));
        sendWord(makeI(opOri, 5'd0, 5'd9, 16'h00F0));

        // Unsupported words mixed into legal traffic
        for (int n = 0; n < 40; n++) begin
            coin = nextRandom();
            if (coin % 3 == 0) begin
                sendWord(randomIllegal());
            end else begin
                sendWord(randomLegal(randomReg(), randomReg(), randomReg()));
            end
        end
        releaseBus();
        waitDrained();

        coin = nextRandom();
        showRegister(1 + int'(coin % 31));
        coin = nextRandom();
        showRegister(1 + int'(coin % 31));
        showRegister(20);

        $display("Run complete: %0d mismatches, %0d other errors", mismatchCount, otherErrors);
        if (mismatchCount == 0 && otherErrors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- mipsCore.f
mipsIsaPkg.sv
mipsPipePkg.sv
mipsIssueIf.sv
mipsRegisterFile.sv
mipsIssue.sv
mipsRegisterAlu.sv
mipsImmediateAlu.sv
mipsWriteback.sv
mipsRegisterViewer.sv
mipsCore.sv
tbClockGen.sv
mipsCoreTb.sv

//--- runSim.sh
#!/bin/sh
# Build and run the mipsCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module mipsCoreTb -Mdir obj_dir -f mipsCore.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/VmipsCoreTb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q '^RESULT: PASS$'; then
    exit 0
fi
exit 1
